// File: hdl/amo_pkg.sv
package amo_pkg;

    parameter int XLEN = 32;
    parameter int TAG_W = 6;      // Instruction tag width.
    parameter int REG_W = 5;      // Destination register number width.
    parameter int PAGE_BITS = 12; // Page offset width.

    typedef enum logic [3:0] {
        AMO_LR,
        AMO_SC,
        AMO_SWAP,
        AMO_ADD,
        AMO_AND,
        AMO_OR,
        AMO_XOR,
        AMO_MAX,
        AMO_MIN,
        AMO_MAXU,
        AMO_MINU
    } amo_op_e;

    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_LOAD_MISALIGN,
        EXC_STORE_MISALIGN,
        EXC_LOAD_PAGE_FAULT,
        EXC_STORE_PAGE_FAULT
    } exc_e;

    // Sequencing states of the single-entry queue.
    typedef enum logic [2:0] {
        Q_IDLE,
        Q_CHECK,
        Q_XLATE,
        Q_MEM,
        Q_WB
    } queue_state_e;

endpackage

// File: hdl/amo_ifs.sv
`timescale 1ns/10ps

interface amo_tlb_if;
    logic                     req;
    logic                     ack;
    logic [amo_pkg::XLEN-1:0] vaddr;
    logic [amo_pkg::XLEN-1:0] paddr;
    logic                     fault; // Page number out of range.

    modport requester (output req, output vaddr, input ack, input paddr, input fault);
    modport responder (input req, input vaddr, output ack, output paddr, output fault);
endinterface

interface amo_mem_if;
    logic                     req;
    logic                     ack;
    amo_pkg::amo_op_e         op;
    logic [amo_pkg::XLEN-1:0] paddr;
    logic [amo_pkg::XLEN-1:0] wdata;
    logic [amo_pkg::XLEN-1:0] rdata; // Old word, or SC status.

    modport requester (output req, output op, output paddr, output wdata,
                       input ack, input rdata);
    modport responder (input req, input op, input paddr, input wdata,
                       output ack, output rdata);
endinterface

// File: hdl/amo_queue.sv
`timescale 1ns/10ps

module amo_queue (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_req,
    output logic                      issue_ack,
    input  amo_pkg::amo_op_e          issue_op,
    input  logic [amo_pkg::XLEN-1:0]  issue_rs1,
    input  logic [amo_pkg::XLEN-1:0]  issue_rs2,
    input  logic [amo_pkg::REG_W-1:0] issue_rd,
    input  logic [amo_pkg::TAG_W-1:0] issue_tag,
    output logic                      flush_req,
    input  logic                      flush_ack,
    amo_tlb_if.requester              tlb,
    amo_mem_if.requester              mem,
    output logic                      wb_req,
    input  logic                      wb_ack,
    output logic [amo_pkg::TAG_W-1:0] wb_tag,
    output logic [amo_pkg::REG_W-1:0] wb_rd,
    output logic [amo_pkg::XLEN-1:0]  wb_data,
    output amo_pkg::exc_e             wb_exc
);
    amo_pkg::queue_state_e     state;
    amo_pkg::amo_op_e          op_q;
    logic [amo_pkg::XLEN-1:0]  rs1_q;
    logic [amo_pkg::XLEN-1:0]  rs2_q;
    logic [amo_pkg::REG_W-1:0] rd_q;
    logic [amo_pkg::TAG_W-1:0] tag_q;
    logic [amo_pkg::XLEN-1:0]  paddr_q;
    logic                      fault_q;
    logic                      tlb_done;
    logic                      flush_done;
    logic                      misalign;
    logic                      is_lr;

    assign misalign = rs1_q[1:0] != 2'b00;
    assign is_lr = op_q == amo_pkg::AMO_LR;

    assign tlb.vaddr = rs1_q;
    assign mem.op = op_q;
    assign mem.paddr = paddr_q;
    assign mem.wdata = rs2_q;
    assign wb_tag = tag_q;
    assign wb_rd = rd_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= amo_pkg::Q_IDLE;
            issue_ack <= 1'b0;
            flush_req <= 1'b0;
            tlb.req <= 1'b0;
            mem.req <= 1'b0;
            wb_req <= 1'b0;
            tlb_done <= 1'b0;
            flush_done <= 1'b0;
        end else begin
            if (issue_ack && !issue_req) begin
                issue_ack <= 1'b0;
            end
            case (state)
                amo_pkg::Q_IDLE: begin
                    if (issue_req && !issue_ack) begin
                        issue_ack <= 1'b1;
                        state <= amo_pkg::Q_CHECK;
                    end
                end
                amo_pkg::Q_CHECK: begin
                    if (misalign) begin
                        wb_req <= 1'b1; // Nothing leaves the unit but the writeback.
                        state <= amo_pkg::Q_WB;
                    end else begin
                        tlb.req <= 1'b1;
                        flush_req <= 1'b1;
                        tlb_done <= 1'b0;
                        flush_done <= 1'b0;
                        state <= amo_pkg::Q_XLATE;
                    end
                end
                amo_pkg::Q_XLATE: begin
                    if (tlb.req && tlb.ack) begin
                        tlb.req <= 1'b0;
                    end else if (!tlb.req && !tlb.ack) begin
                        tlb_done <= 1'b1;
                    end
                    if (flush_req && flush_ack) begin
                        flush_req <= 1'b0;
                    end else if (!flush_req && !flush_ack) begin
                        flush_done <= 1'b1;
                    end
                    if (tlb_done && flush_done) begin
                        if (fault_q) begin
                            wb_req <= 1'b1;
                            state <= amo_pkg::Q_WB;
                        end else begin
                            mem.req <= 1'b1;
                            state <= amo_pkg::Q_MEM;
                        end
                    end
                end
                amo_pkg::Q_MEM: begin
                    if (mem.req && mem.ack) begin
                        mem.req <= 1'b0;
                    end else if (!mem.req && !mem.ack) begin
                        wb_req <= 1'b1;
                        state <= amo_pkg::Q_WB;
                    end
                end
                amo_pkg::Q_WB: begin
                    if (wb_req && wb_ack) begin
                        wb_req <= 1'b0;
                    end else if (!wb_req && !wb_ack) begin
                        state <= amo_pkg::Q_IDLE;
                    end
                end
                default: state <= amo_pkg::Q_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == amo_pkg::Q_IDLE && issue_req && !issue_ack) begin
            op_q <= issue_op;
            rs1_q <= issue_rs1;
            rs2_q <= issue_rs2;
            rd_q <= issue_rd;
            tag_q <= issue_tag;
        end
        if (state == amo_pkg::Q_CHECK && misalign) begin
            wb_data <= '0;
            wb_exc <= is_lr ? amo_pkg::EXC_LOAD_MISALIGN : amo_pkg::EXC_STORE_MISALIGN;
        end
        if (tlb.req && tlb.ack) begin
            paddr_q <= tlb.paddr;
            fault_q <= tlb.fault;
        end
        if (state == amo_pkg::Q_XLATE && tlb_done && flush_done && fault_q) begin
            wb_data <= '0;
            wb_exc <= is_lr ? amo_pkg::EXC_LOAD_PAGE_FAULT : amo_pkg::EXC_STORE_PAGE_FAULT;
        end
        if (mem.req && mem.ack) begin
            wb_data <= mem.rdata;
            wb_exc <= amo_pkg::EXC_NONE;
        end
    end

    // Every requester holds req until the other side has answered.
    assert property (@(posedge clk) disable iff (rst)
        $fell(flush_req) |-> $past(flush_ack));
    assert property (@(posedge clk) disable iff (rst)
        $fell(tlb.req) |-> $past(tlb.ack));
    assert property (@(posedge clk) disable iff (rst)
        $fell(mem.req) |-> $past(mem.ack));
    assert property (@(posedge clk) disable iff (rst)
        $fell(wb_req) |-> $past(wb_ack));

    // The store path must be drained before the memory sees the atomic.
    assert property (@(posedge clk) disable iff (rst)
        mem.req |-> !flush_req && !flush_ack);
endmodule

// File: hdl/amo_translate.sv
`timescale 1ns/10ps

module amo_translate #(
    parameter int NUM_PAGES = 4,
    parameter int MEM_WORDS = 64
) (
    input logic          clk,
    input logic          rst,
    amo_tlb_if.responder tlb
);
    localparam int PA_W = $clog2(MEM_WORDS) + 2;

    logic [7:0]                                    lfsr;
    logic [1:0]                                    wait_cnt;
    logic [amo_pkg::XLEN-amo_pkg::PAGE_BITS-1:0] vpn;
    logic                                          lfsr_fb;

    assign vpn = tlb.vaddr[amo_pkg::XLEN-1:amo_pkg::PAGE_BITS];
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            tlb.ack <= 1'b0;
            wait_cnt <= 2'd0;
            lfsr <= 8'ha5;
        end else if (tlb.ack) begin
            if (!tlb.req) begin
                tlb.ack <= 1'b0;
            end
        end else if (tlb.req) begin
            if (wait_cnt == lfsr[1:0]) begin // Delay stays fixed until the answer.
                tlb.ack <= 1'b1;
                wait_cnt <= 2'd0;
                lfsr <= {lfsr[6:0], lfsr_fb};
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlb.req && !tlb.ack && wait_cnt == lfsr[1:0]) begin
            tlb.fault <= vpn >= NUM_PAGES;
            tlb.paddr <= amo_pkg::XLEN'(tlb.vaddr[PA_W-1:0]); // Wraps to the memory size.
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $rose(tlb.ack) |-> $past(tlb.req));
endmodule

// File: hdl/amo_data_mem.sv
`timescale 1ns/10ps

module amo_data_mem #(
    parameter int MEM_WORDS = 64
) (
    input logic          clk,
    input logic          rst,
    amo_mem_if.responder mem
);
    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [amo_pkg::XLEN-1:0] words [MEM_WORDS];
    logic                     resv_valid;
    logic [IDX_W-1:0]         resv_idx;
    logic [IDX_W-1:0]         idx;
    logic [amo_pkg::XLEN-1:0] old_word;
    logic [amo_pkg::XLEN-1:0] new_word;
    logic                     sc_ok;
    logic                     we;
    logic                     start;

    assign idx = mem.paddr[IDX_W+1:2];
    assign old_word = words[idx];
    assign sc_ok = resv_valid && resv_idx == idx;
    assign start = mem.req && !mem.ack;

    always_comb begin
        case (mem.op)
            amo_pkg::AMO_ADD:  new_word = old_word + mem.wdata;
            amo_pkg::AMO_AND:  new_word = old_word & mem.wdata;
            amo_pkg::AMO_OR:   new_word = old_word | mem.wdata;
            amo_pkg::AMO_XOR:  new_word = old_word ^ mem.wdata;
            amo_pkg::AMO_MAX:  new_word = $signed(old_word) > $signed(mem.wdata) ? old_word : mem.wdata;
            amo_pkg::AMO_MIN:  new_word = $signed(old_word) < $signed(mem.wdata) ? old_word : mem.wdata;
            amo_pkg::AMO_MAXU: new_word = old_word > mem.wdata ? old_word : mem.wdata;
            amo_pkg::AMO_MINU: new_word = old_word < mem.wdata ? old_word : mem.wdata;
            default:           new_word = mem.wdata; // SWAP and SC store the operand.
        endcase
    end

    assign we = start && mem.op != amo_pkg::AMO_LR && (mem.op != amo_pkg::AMO_SC || sc_ok);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            mem.ack <= 1'b0;
            resv_valid <= 1'b0;
            resv_idx <= '0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                words[i] <= '0;
            end
        end else begin
            if (start) begin
                mem.ack <= 1'b1;
            end else if (mem.ack && !mem.req) begin
                mem.ack <= 1'b0;
            end
            if (we) begin
                words[idx] <= new_word;
            end
            if (start && mem.op == amo_pkg::AMO_LR) begin
                resv_valid <= 1'b1;
                resv_idx <= idx;
            end else if (start && mem.op == amo_pkg::AMO_SC) begin
                resv_valid <= 1'b0;
            end else if (we && resv_idx == idx) begin
                resv_valid <= 1'b0; // A store to the reserved word breaks the LR/SC pair.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (mem.op == amo_pkg::AMO_SC) begin
                mem.rdata <= sc_ok ? '0 : amo_pkg::XLEN'(1);
            end else begin
                mem.rdata <= old_word;
            end
        end
    end

    // Misaligned atomics are trapped before they reach the memory.
    assert property (@(posedge clk) disable iff (rst)
        mem.req |-> mem.paddr[1:0] == 2'b00);
endmodule

// File: hdl/amo_unit_top.sv
`timescale 1ns/10ps

module amo_unit_top #(
    parameter int MEM_WORDS = 64,
    parameter int NUM_PAGES = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_req,
    output logic                      issue_ack,
    input  amo_pkg::amo_op_e          issue_op,
    input  logic [amo_pkg::XLEN-1:0]  issue_rs1,
    input  logic [amo_pkg::XLEN-1:0]  issue_rs2,
    input  logic [amo_pkg::REG_W-1:0] issue_rd,
    input  logic [amo_pkg::TAG_W-1:0] issue_tag,
    output logic                      flush_req,
    input  logic                      flush_ack,
    output logic                      wb_req,
    input  logic                      wb_ack,
    output logic [amo_pkg::TAG_W-1:0] wb_tag,
    output logic [amo_pkg::REG_W-1:0] wb_rd,
    output logic [amo_pkg::XLEN-1:0]  wb_data,
    output amo_pkg::exc_e             wb_exc
);
    amo_tlb_if tlb_if ();
    amo_mem_if mem_if ();

    amo_queue amo_queue_i (
        .clk       (clk),
        .rst       (rst),
        .issue_req (issue_req),
        .issue_ack (issue_ack),
        .issue_op  (issue_op),
        .issue_rs1 (issue_rs1),
        .issue_rs2 (issue_rs2),
        .issue_rd  (issue_rd),
        .issue_tag (issue_tag),
        .flush_req (flush_req),
        .flush_ack (flush_ack),
        .tlb       (tlb_if.requester),
        .mem       (mem_if.requester),
        .wb_req    (wb_req),
        .wb_ack    (wb_ack),
        .wb_tag    (wb_tag),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .wb_exc    (wb_exc)
    );

    amo_translate #(
        .NUM_PAGES (NUM_PAGES),
        .MEM_WORDS (MEM_WORDS)
    ) amo_translate_i (
        .clk (clk),
        .rst (rst),
        .tlb (tlb_if.responder)
    );

    amo_data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) amo_data_mem_i (
        .clk (clk),
        .rst (rst),
        .mem (mem_if.responder)
    );
endmodule

// File: verification/amo_model.svh
`ifndef AMO_MODEL_SVH
`define AMO_MODEL_SVH

logic [amo_pkg::XLEN-1:0] ref_mem [MEM_WORDS] = '{default: '0}; // Matches the cleared DUT memory.
bit                       resv_valid = 1'b0;
int                       resv_idx = 0;

function automatic int word_index(logic [amo_pkg::XLEN-1:0] addr);
    return int'((addr >> 2) % MEM_WORDS);
endfunction

function automatic logic [amo_pkg::XLEN-1:0] apply_op(amo_pkg::amo_op_e op,
                                                      logic [amo_pkg::XLEN-1:0] old,
                                                      logic [amo_pkg::XLEN-1:0] opnd);
    case (op)
        amo_pkg::AMO_ADD:  return old + opnd;
        amo_pkg::AMO_AND:  return old & opnd;
        amo_pkg::AMO_OR:   return old | opnd;
        amo_pkg::AMO_XOR:  return old ^ opnd;
        amo_pkg::AMO_MAX:  return $signed(old) > $signed(opnd) ? old : opnd;
        amo_pkg::AMO_MIN:  return $signed(old) < $signed(opnd) ? old : opnd;
        amo_pkg::AMO_MAXU: return old > opnd ? old : opnd;
        amo_pkg::AMO_MINU: return old < opnd ? old : opnd;
        default:           return opnd;
    endcase
endfunction

function automatic amo_pkg::exc_e expected_exc(amo_pkg::amo_op_e op,
                                               logic [amo_pkg::XLEN-1:0] addr);
    bit load;
    load = op == amo_pkg::AMO_LR;
    if (addr[1:0] != 2'b00) begin
        return load ? amo_pkg::EXC_LOAD_MISALIGN : amo_pkg::EXC_STORE_MISALIGN;
    end
    if ((addr >> amo_pkg::PAGE_BITS) >= NUM_PAGES) begin
        return load ? amo_pkg::EXC_LOAD_PAGE_FAULT : amo_pkg::EXC_STORE_PAGE_FAULT;
    end
    return amo_pkg::EXC_NONE;
endfunction

// Performs one atomic on the reference memory and returns the expected wb_data.
function automatic logic [amo_pkg::XLEN-1:0] execute_ref(amo_pkg::amo_op_e op,
                                                         logic [amo_pkg::XLEN-1:0] addr,
                                                         logic [amo_pkg::XLEN-1:0] data);
    int                       idx;
    logic [amo_pkg::XLEN-1:0] old;
    idx = word_index(addr);
    old = ref_mem[idx];
    if (op == amo_pkg::AMO_LR) begin
        resv_valid = 1'b1;
        resv_idx = idx;
        return old;
    end
    if (op == amo_pkg::AMO_SC) begin
        old = (resv_valid && resv_idx == idx) ? '0 : 1;
        if (old == 0) ref_mem[idx] = data;
        resv_valid = 1'b0;
        return old;
    end
    ref_mem[idx] = apply_op(op, old, data);
    if (resv_idx == idx) resv_valid = 1'b0;
    return old;
endfunction

`endif

// File: verification/amo_unit_tb.sv
`timescale 1ns/10ps

module amo_unit_tb;
    localparam int MEM_WORDS = 64;
    localparam int NUM_PAGES = 4;
    localparam int TIMEOUT = 200; // Cycles allowed for any single wait.

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      issue_req;
    logic                      issue_ack;
    amo_pkg::amo_op_e          issue_op;
    logic [amo_pkg::XLEN-1:0]  issue_rs1;
    logic [amo_pkg::XLEN-1:0]  issue_rs2;
    logic [amo_pkg::REG_W-1:0] issue_rd;
    logic [amo_pkg::TAG_W-1:0] issue_tag;
    logic                      flush_req;
    logic                      flush_ack;
    logic                      wb_req;
    logic                      wb_ack;
    logic [amo_pkg::TAG_W-1:0] wb_tag;
    logic [amo_pkg::REG_W-1:0] wb_rd;
    logic [amo_pkg::XLEN-1:0]  wb_data;
    amo_pkg::exc_e             wb_exc;
    logic                      busy = 1'b0; // An operation was accepted and is not yet written back.
    logic [amo_pkg::TAG_W-1:0] pend_tag;    // Expected writeback of the operation in flight.
    logic [amo_pkg::REG_W-1:0] pend_rd;
    logic [amo_pkg::XLEN-1:0]  pend_data;
    amo_pkg::exc_e             pend_exc;
    bit                        pend_flush;

    `include "amo_model.svh"

    always #4 clk = ~clk;

    amo_unit_top #(
        .MEM_WORDS (MEM_WORDS),
        .NUM_PAGES (NUM_PAGES)
    ) amo_unit_top_i (.*);

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic tick_or_timeout(inout int cnt, input string what);
        @(negedge clk);
        cnt++;
        if (cnt > TIMEOUT) begin
            $display("Error at %0t: timed out waiting for %s", $time, what);
            stop_run();
        end
    endtask

    function automatic logic [amo_pkg::XLEN-1:0] mapped_addr();
        return (32'($urandom_range(0, NUM_PAGES - 1)) << amo_pkg::PAGE_BITS)
               | ($urandom & 32'hffc);
    endfunction

    // Answers the flush and writeback of the operation in flight and checks its result.
    task automatic finish_op();
        int cnt;
        int flush_delay;
        bit flush_raised;
        bit flush_acked;
        flush_delay = $urandom_range(0, 8);
        flush_raised = 1'b0;
        flush_acked = 1'b0;
        cnt = 0;
        while (!wb_req) begin
            if (flush_req) flush_raised = 1'b1;
            if (flush_req && !flush_ack) begin
                if (flush_delay == 0) begin
                    flush_ack = 1'b1;
                    flush_acked = 1'b1;
                end else begin
                    flush_delay--;
                end
            end else if (!flush_req && flush_ack) begin
                flush_ack = 1'b0;
            end
            tick_or_timeout(cnt, "wb_req");
        end
        check_value("wb_tag", wb_tag, pend_tag);
        check_value("wb_rd", wb_rd, pend_rd);
        check_value("wb_data", wb_data, pend_data);
        check_value("wb_exc", wb_exc, pend_exc);
        check_value("flush_req raised", flush_raised, pend_flush);
        assert (pend_exc != amo_pkg::EXC_NONE || flush_acked) else begin
            $display("Error at %0t: writeback came before flush_ack", $time);
            stop_run();
        end
        repeat ($urandom_range(0, 8)) @(negedge clk);
        wb_ack = 1'b1;
        cnt = 0;
        while (wb_req) tick_or_timeout(cnt, "wb_req to fall");
        wb_ack = 1'b0;
        busy = 1'b0;
    endtask

    // The next request is raised while the previous operation is still in flight.
    task automatic run_op(input amo_pkg::amo_op_e op, input logic [amo_pkg::XLEN-1:0] addr,
                          input logic [amo_pkg::XLEN-1:0] data);
        logic [amo_pkg::XLEN-1:0]  exp_data;
        amo_pkg::exc_e             exp_exc;
        logic [amo_pkg::TAG_W-1:0] tag;
        logic [amo_pkg::REG_W-1:0] rd;
        int                        cnt;
        tag = $urandom;
        rd = $urandom;
        exp_exc = expected_exc(op, addr);
        exp_data = exp_exc == amo_pkg::EXC_NONE ? execute_ref(op, addr, data) : '0;
        @(negedge clk);
        issue_req = 1'b1;
        issue_op = op;
        issue_rs1 = addr;
        issue_rs2 = data;
        issue_rd = rd;
        issue_tag = tag;
        if (busy) begin
            finish_op();
        end
        cnt = 0;
        while (!issue_ack) tick_or_timeout(cnt, "issue_ack to rise");
        issue_req = 1'b0;
        cnt = 0;
        while (issue_ack) tick_or_timeout(cnt, "issue_ack to fall");
        busy = 1'b1;
        pend_tag = tag;
        pend_rd = rd;
        pend_data = exp_data;
        pend_exc = exp_exc;
        pend_flush = addr[1:0] == 2'b00;
    endtask

    // The writeback must hold still until it is acknowledged.
    assert property (@(posedge clk) disable iff (rst)
        wb_req && !wb_ack |=> wb_req && $stable(wb_data) && $stable(wb_exc)
                              && $stable(wb_tag) && $stable(wb_rd))
    else begin
        $display("Error at %0t: wb_req dropped or its data changed before wb_ack", $time);
        stop_run();
    end

    assert property (@(posedge clk) disable iff (rst) busy |-> !issue_ack)
    else begin
        $display("Error at %0t: issue_ack rose while an operation was in flight", $time);
        stop_run();
    end

    initial begin
        logic [amo_pkg::XLEN-1:0] addr;
        amo_pkg::amo_op_e         op;
        void'($urandom(32'h4cd855e4));
        rst = 1'b1;
        issue_req = 1'b0;
        issue_op = amo_pkg::AMO_LR;
        issue_rs1 = '0;
        issue_rs2 = '0;
        issue_rd = '0;
        issue_tag = '0;
        flush_ack = 1'b0;
        wb_ack = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("issue_ack", issue_ack, 0);
        check_value("flush_req", flush_req, 0);
        check_value("wb_req", wb_req, 0);
        run_op(amo_pkg::AMO_SWAP, 32'h10, $urandom);
        for (int i = 0; i < 8; i++) begin
            run_op(amo_pkg::AMO_OR, 32'(i * 4), '0);
        end
        repeat (40) begin
            addr = mapped_addr();
            op = amo_pkg::amo_op_e'($urandom_range(2, 10));
            run_op(op, addr, $urandom);
            run_op(amo_pkg::AMO_OR, addr, '0);
        end
        addr = mapped_addr();
        run_op(amo_pkg::AMO_LR, addr, '0);
        run_op(amo_pkg::AMO_SC, addr, $urandom);
        run_op(amo_pkg::AMO_OR, addr, '0);
        run_op(amo_pkg::AMO_SC, addr, $urandom);
        run_op(amo_pkg::AMO_LR, addr, '0);
        run_op(amo_pkg::AMO_ADD, addr, 32'h5);
        run_op(amo_pkg::AMO_SC, addr, $urandom);
        run_op(amo_pkg::AMO_OR, addr, '0);
        repeat (12) begin
            op = amo_pkg::amo_op_e'($urandom_range(0, 10));
            addr = mapped_addr() | 32'($urandom_range(1, 3));
            run_op(op, addr, $urandom);
            run_op(amo_pkg::AMO_OR, addr & ~32'h3, '0);
            addr = (32'($urandom_range(NUM_PAGES, 20'hfffff)) << amo_pkg::PAGE_BITS)
                   | ($urandom & 32'hffc);
            run_op(op, addr, $urandom);
            run_op(amo_pkg::AMO_OR, addr & 32'hffc, '0);
        end
        repeat (40) begin
            op = amo_pkg::amo_op_e'($urandom_range(0, 10));
            run_op(op, 32'($urandom_range(0, 3)) << 2, $urandom);
        end
        finish_op();
        $display("All checks passed");
        $finish;
    end
endmodule

// File: build.f
+incdir+verification
hdl/amo_pkg.sv
hdl/amo_ifs.sv
hdl/amo_queue.sv
hdl/amo_translate.sv
hdl/amo_data_mem.sv
hdl/amo_unit_top.sv
verification/amo_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the AMO unit testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module amo_unit_tb \
    -f build.f -o amo_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/amo_unit_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "All checks passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
